// File: src/norm_div_pkg.sv
package norm_div_pkg;

    // operand and result width
    localparam int DATA_W = 32;

    // bit length and iteration count, holds 0 to DATA_W
    localparam int CNT_W = 6;

    typedef logic [DATA_W-1:0]   data_t;

    // partial remainder and aligned divisor
    typedef logic [2*DATA_W-1:0] wide_t;

    // significant bits of a magnitude, zero for a zero value
    typedef logic [CNT_W-1:0]    bitlen_t;

    // one prepared operand
    typedef struct packed {
        data_t   magnitude;
        bitlen_t bitlen;
        logic    negative;
    } operand_info_t;

    typedef struct packed {
        data_t quotient;
        data_t remainder;
    } div_result_t;

    // core sequence
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        CHECK,
        CALC,
        FIXUP,
        DONE
    } div_state_e;

endpackage

// File: src/div_operand_prep.sv
`timescale 1ns/100ps

module div_operand_prep (
    input  norm_div_pkg::data_t         value,
    input  logic                        sign,
    output norm_div_pkg::operand_info_t info
);

    logic                  neg;
    norm_div_pkg::data_t   mag;
    norm_div_pkg::bitlen_t len;

    // only a signed operation sees the top bit as a sign
    assign neg = sign & value[norm_div_pkg::DATA_W-1];

    // two's complement magnitude
    // the most negative value maps onto itself, which is still right unsigned
    assign mag = neg ? (~value + 1'b1) : value;

    // leading one search, the highest set bit wins
    always_comb begin
        len = '0;
        for (int i = 0; i < norm_div_pkg::DATA_W; i++) begin
            if (mag[i]) begin
                len = norm_div_pkg::bitlen_t'(i + 1);
            end
        end
    end

    assign info = '{
        magnitude: mag,
        bitlen:    len,
        negative:  neg
    };

endmodule

// File: src/div_iter_core.sv
`timescale 1ns/100ps

module div_iter_core (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        en,
    input  logic                        flush,
    input  norm_div_pkg::operand_info_t dvd_info,
    input  norm_div_pkg::operand_info_t dvs_info,
    output logic                        busy,
    output logic                        ready,
    output norm_div_pkg::div_result_t   result
);

    norm_div_pkg::div_state_e    state;
    norm_div_pkg::div_state_e    state_nxt;

    // operands as sampled on the accepting edge
    norm_div_pkg::operand_info_t dvd_q;
    norm_div_pkg::operand_info_t dvs_q;

    // length difference and the alignment shift derived from it
    norm_div_pkg::bitlen_t       diff_q;
    norm_div_pkg::bitlen_t       align_sh;

    logic                        early_q;
    logic                        quo_neg_q;
    logic [norm_div_pkg::CNT_W-1:0] iter_cnt;

    // working registers of the restoring loop
    norm_div_pkg::wide_t         rem_q;
    norm_div_pkg::wide_t         dvs_w;
    norm_div_pkg::wide_t         trial;
    norm_div_pkg::wide_t         minus;
    norm_div_pkg::data_t         quo_q;

    norm_div_pkg::data_t         early_rem;
    norm_div_pkg::data_t         quo_fix;
    norm_div_pkg::data_t         rem_fix;
    norm_div_pkg::div_result_t   result_q;

    function automatic norm_div_pkg::data_t neg_if(
        input logic                neg,
        input norm_div_pkg::data_t v
    );
        return neg ? (~v + 1'b1) : v;
    endfunction

    // divisor one place lower, then the trial subtraction
    assign trial    = dvs_w >> 1;
    assign minus    = rem_q - trial;

    // placed one above the dividend's leading one so the first CALC brings it in line
    assign align_sh = diff_q + norm_div_pkg::bitlen_t'(1);

    // sign correction of the results
    assign early_rem = neg_if(dvd_q.negative, dvd_q.magnitude);
    assign quo_fix   = neg_if(quo_neg_q, quo_q);
    assign rem_fix   = neg_if(dvd_q.negative, rem_q[norm_div_pkg::DATA_W-1:0]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= norm_div_pkg::IDLE;
        end else if (flush) begin
            state <= norm_div_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            norm_div_pkg::IDLE: begin
                if (en) begin
                    state_nxt = norm_div_pkg::LOAD;
                end
            end
            norm_div_pkg::LOAD: begin
                state_nxt = norm_div_pkg::CHECK;
            end
            norm_div_pkg::CHECK: begin
                state_nxt = early_q ? norm_div_pkg::DONE : norm_div_pkg::CALC;
            end
            norm_div_pkg::CALC: begin
                // last quotient bit this cycle
                if (iter_cnt == norm_div_pkg::CNT_W'(1)) begin
                    state_nxt = norm_div_pkg::FIXUP;
                end
            end
            norm_div_pkg::FIXUP: begin
                state_nxt = norm_div_pkg::DONE;
            end
            norm_div_pkg::DONE: begin
                state_nxt = norm_div_pkg::IDLE;
            end
            default: begin
                state_nxt = norm_div_pkg::IDLE;
            end
        endcase
    end

    // control registers and the result
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            early_q  <= 1'b0;
            iter_cnt <= '0;
            result_q <= '0;
        end else if (flush) begin
            early_q  <= 1'b0;
            iter_cnt <= '0;
            result_q <= '0;
        end else begin
            // result only holds a value during DONE
            result_q <= '0;
            case (state)
                norm_div_pkg::LOAD: begin
                    // divisor longer than dividend, or a zero divisor
                    early_q <= (dvs_q.bitlen > dvd_q.bitlen) || (dvs_q.bitlen == '0);
                end
                norm_div_pkg::CHECK: begin
                    if (early_q) begin
                        result_q.quotient  <= '0;
                        result_q.remainder <= early_rem;
                    end else begin
                        iter_cnt <= align_sh;
                    end
                end
                norm_div_pkg::CALC: begin
                    iter_cnt <= iter_cnt - 1'b1;
                end
                norm_div_pkg::FIXUP: begin
                    result_q.quotient  <= quo_fix;
                    result_q.remainder <= rem_fix;
                end
            endcase
        end
    end

    // operand and datapath registers
    always_ff @(posedge clk) begin
        if (flush) begin
            dvd_q     <= '0;
            dvs_q     <= '0;
            diff_q    <= '0;
            quo_neg_q <= 1'b0;
            rem_q     <= '0;
            dvs_w     <= '0;
            quo_q     <= '0;
        end else begin
            case (state)
                norm_div_pkg::IDLE: begin
                    if (en) begin
                        dvd_q <= dvd_info;
                        dvs_q <= dvs_info;
                    end
                end
                norm_div_pkg::LOAD: begin
                    rem_q     <= norm_div_pkg::wide_t'(dvd_q.magnitude);
                    quo_q     <= '0;
                    diff_q    <= dvd_q.bitlen - dvs_q.bitlen;
                    quo_neg_q <= dvd_q.negative ^ dvs_q.negative;
                end
                norm_div_pkg::CHECK: begin
                    dvs_w <= norm_div_pkg::wide_t'(dvs_q.magnitude) << align_sh;
                end
                norm_div_pkg::CALC: begin
                    dvs_w <= trial;
                    // restore by keeping the old remainder when negative
                    if (!minus[2*norm_div_pkg::DATA_W-1]) begin
                        rem_q <= minus;
                    end
                    quo_q <= {quo_q[norm_div_pkg::DATA_W-2:0],
                              ~minus[2*norm_div_pkg::DATA_W-1]};
                end
            endcase
        end
    end

    assign busy   = (state != norm_div_pkg::IDLE);
    assign ready  = (state == norm_div_pkg::DONE);
    assign result = result_q;

endmodule

// File: src/norm_divider.sv
`timescale 1ns/100ps

module norm_divider (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      en,
    input  logic                      sign,
    input  logic                      flush,
    input  norm_div_pkg::data_t       dividend,
    input  norm_div_pkg::data_t       divisor,
    output logic                      busy,
    output logic                      ready,
    output norm_div_pkg::div_result_t result
);

    norm_div_pkg::operand_info_t dvd_info;
    norm_div_pkg::operand_info_t dvs_info;

    // dividend magnitude and length
    div_operand_prep u_dvd_prep (
        .value (dividend),
        .sign  (sign),
        .info  (dvd_info)
    );

    // divisor magnitude and length
    div_operand_prep u_dvs_prep (
        .value (divisor),
        .sign  (sign),
        .info  (dvs_info)
    );

    // sequencing, iteration and sign correction
    div_iter_core u_core (
        .clk      (clk),
        .rstn     (rstn),
        .en       (en),
        .flush    (flush),
        .dvd_info (dvd_info),
        .dvs_info (dvs_info),
        .busy     (busy),
        .ready    (ready),
        .result   (result)
    );

endmodule

// File: bench/tb_div_model.svh
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1, the new bit enters at the bottom
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// number of significant bits, zero for a zero value
function automatic int bit_length(input logic [31:0] m);
    int          len;
    logic [31:0] rest;
    len  = 0;
    rest = m;
    while (rest != '0) begin
        len++;
        rest = rest >> 1;
    end
    return len;
endfunction

// quotient truncated toward zero, remainder carries the dividend's sign
function automatic norm_div_pkg::div_result_t model_divide(
    input logic [31:0] a,
    input logic [31:0] b,
    input logic        sgn
);
    longint                    num;
    longint                    den;
    longint                    quo;
    longint                    rem;
    norm_div_pkg::div_result_t res;
    if (sgn) begin
        num = {{32{a[31]}}, a};
        den = {{32{b[31]}}, b};
    end else begin
        num = {32'h0, a};
        den = {32'h0, b};
    end
    if (den == 0) begin
        res.quotient  = '0;
        res.remainder = a;
    end else begin
        // 64-bit signed / and % already round toward zero
        quo           = num / den;
        rem           = num % den;
        // most negative by minus one wraps here
        res.quotient  = quo[31:0];
        res.remainder = rem[31:0];
    end
    return res;
endfunction

// edges from acceptance to the edge that sees ready
// early exit: LOAD, CHECK, DONE
// otherwise LOAD, CHECK, one CALC per quotient bit, FIXUP, DONE
function automatic int model_latency(
    input logic [31:0] a,
    input logic [31:0] b,
    input logic        sgn
);
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    int          la;
    int          lb;
    mag_a = (sgn && a[31]) ? -a : a;
    mag_b = (sgn && b[31]) ? -b : b;
    la    = bit_length(mag_a);
    lb    = bit_length(mag_b);
    if (lb == 0 || lb > la) begin
        return 3;
    end else begin
        return la - lb + 5;
    end
endfunction

`endif

// File: bench/tb_norm_divider.sv
`timescale 1ns/100ps

module tb_norm_divider;

    localparam logic [31:0] LFSR_SEED   = 32'hacb2_7ec4;
    localparam int          N_DIV       = 600;
    // 40 cycles cover the slowest division plus the issue overhead
    localparam int          CYCLE_LIMIT = N_DIV * 40 + 100;
    localparam int          LONG_RUNS   = 20;
    localparam int          RANDOM_DIVS = 440;
    localparam int          FLUSH_RUNS  = 30;
    localparam int          MAX_WAIT    = 38;

    logic                      clk = 1'b0;
    logic                      rstn;
    logic                      en;
    logic                      sign;
    logic                      flush;
    norm_div_pkg::data_t       dividend;
    norm_div_pkg::data_t       divisor;
    logic                      busy;
    logic                      ready;
    norm_div_pkg::div_result_t result;

    // scoreboard
    logic                      accept;
    logic                      in_flight;
    int                        wait_cnt;
    int                        exp_lat;
    norm_div_pkg::div_result_t exp_res;
    int                        done_cnt;
    int                        expect_done;
    int                        cycle_cnt = 0;
    logic [31:0]               lfsr_q;

    `include "tb_div_model.svh"

    norm_divider i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .en       (en),
        .sign     (sign),
        .flush    (flush),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (busy),
        .ready    (ready),
        .result   (result)
    );

    always #5 clk = ~clk;

    // flush wins over en in the core
    assign accept = en && !busy && !flush;

    // expected result and cycle count of the division in flight
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_flight <= 1'b0;
            wait_cnt  <= 0;
            exp_lat   <= 0;
            exp_res   <= '0;
            done_cnt  <= 0;
        end else if (flush) begin
            in_flight <= 1'b0;
            wait_cnt  <= 0;
        end else if (accept) begin
            in_flight <= 1'b1;
            wait_cnt  <= 1;
            exp_res   <= model_divide(dividend, divisor, sign);
            exp_lat   <= model_latency(dividend, divisor, sign);
        end else if (in_flight) begin
            if (ready) begin
                in_flight <= 1'b0;
                done_cnt  <= done_cnt + 1;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("timeout, run passed %0d cycles", cycle_cnt));
        end
    end

    a_quotient: assert property (@(posedge clk) disable iff (!rstn)
        ready |-> (result.quotient == exp_res.quotient))
        else flag_mismatch("result.quotient", {32'h0, $sampled(exp_res.quotient)},
                           {32'h0, $sampled(result.quotient)});

    a_remainder: assert property (@(posedge clk) disable iff (!rstn)
        ready |-> (result.remainder == exp_res.remainder))
        else flag_mismatch("result.remainder", {32'h0, $sampled(exp_res.remainder)},
                           {32'h0, $sampled(result.remainder)});

    a_result_idle: assert property (@(posedge clk) disable iff (!rstn)
        !ready |-> (result == '0))
        else flag_mismatch("result", 64'h0, $sampled(result));

    // exactly 3 for the early exits
    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        ready |-> (wait_cnt == exp_lat))
        else flag_mismatch("ready latency", {32'h0, $sampled(exp_lat)},
                           {32'h0, $sampled(wait_cnt)});

    a_ready_bound: assert property (@(posedge clk) disable iff (!rstn)
        in_flight |-> (wait_cnt <= MAX_WAIT))
        else stop_with_failure("no ready pulse within 38 cycles of acceptance");

    a_ready_single: assert property (@(posedge clk) disable iff (!rstn)
        ready |-> !$past(ready))
        else stop_with_failure("ready stayed high for more than one cycle");

    a_ready_owned: assert property (@(posedge clk) disable iff (!rstn)
        ready |-> in_flight)
        else stop_with_failure("ready pulsed with no division in flight");

    // also catches a start from an en while busy
    a_busy_owned: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> in_flight)
        else stop_with_failure("busy went high with no accepted division");

    a_busy_held: assert property (@(posedge clk) disable iff (!rstn)
        in_flight |-> busy)
        else stop_with_failure("busy dropped before the ready pulse");

    a_flush_idle: assert property (@(posedge clk) disable iff (!rstn)
        $past(flush) |-> !busy)
        else stop_with_failure("busy still high in the cycle after a flush");

    task automatic stop_with_failure(input string what);
        $display(">>> FAIL");
        $display("%s", what);
        $fatal(1);
    endtask

    task automatic flag_mismatch(
        input string       name,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        stop_with_failure($sformatf("CHECK FAILED: %s expected 0x%0h actual 0x%0h",
                                    name, expected, actual));
    endtask

    // one LFSR step per bit, first bit ends up on top
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] corner_value(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    // entered just after a rising edge, left on the edge that sees ready
    task automatic divide(
        input logic [31:0] a,
        input logic [31:0] b,
        input logic        sgn,
        input logic        stray
    );
        logic [31:0] junk_a;
        logic [31:0] junk_b;
        en       <= 1'b1;
        dividend <= a;
        divisor  <= b;
        sign     <= sgn;
        @(posedge clk);
        en <= 1'b0;
        expect_done++;
        if (stray) begin
            // second en lands while busy and must be ignored
            take_bits(32, junk_a);
            take_bits(32, junk_b);
            @(posedge clk);
            en       <= 1'b1;
            dividend <= junk_a;
            divisor  <= junk_b;
            sign     <= ~sgn;
            @(posedge clk);
            en <= 1'b0;
        end
        do begin
            @(posedge clk);
        end while (!ready);
    endtask

    task automatic divide_and_flush(input logic [31:0] a, input logic [31:0] b, input int hold);
        en       <= 1'b1;
        dividend <= a;
        divisor  <= b;
        sign     <= 1'b0;
        @(posedge clk);
        en <= 1'b0;
        repeat (hold) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic random_operands(output logic [31:0] a, output logic [31:0] b,
                                   output logic s);
        logic [31:0] bits;
        logic [31:0] sh;
        take_bits(32, a);
        take_bits(32, b);
        take_bits(1, bits);
        s = bits[0];
        // shorter operands, negatives stay negative when signed
        take_bits(5, sh);
        if (s) a = $signed(a) >>> sh[4:0];
        else a = a >> sh[4:0];
        take_bits(5, sh);
        if (s) b = $signed(b) >>> sh[4:0];
        else b = b >> sh[4:0];
        take_bits(3, bits);
        if (bits[2:0] == 3'd0) begin
            b = '0;
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] bits;
        logic        s;
        rstn        = 1'b0;
        en          = 1'b0;
        sign        = 1'b0;
        flush       = 1'b0;
        dividend    = '0;
        divisor     = '0;
        lfsr_q      = LFSR_SEED;
        expect_done = 0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        // quiet cycles before the first en
        repeat (4) @(posedge clk);

        // corners in every pairing, both modes
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    divide(corner_value(i), corner_value(j), m[0], 1'b0);
                end
            end
        end

        // divisor longer than the dividend
        for (int n = 0; n < LONG_RUNS; n++) begin
            for (int m = 0; m < 2; m++) begin
                take_bits(16, a);
                take_bits(32, b);
                take_bits(2, bits);
                b = (b & 32'h7fff_ffff) | 32'h4000_0000;
                if (m == 1 && bits[0]) a = -a;
                if (m == 1 && bits[1]) b = -b;
                divide(a, b, m[0], 1'b0);
            end
        end

        for (int n = 0; n < RANDOM_DIVS; n++) begin
            random_operands(a, b, s);
            take_bits(3, bits);
            divide(a, b, s, bits[2:0] == 3'd0);
        end

        // long unsigned division cut short, then a normal one
        for (int n = 0; n < FLUSH_RUNS; n++) begin
            take_bits(32, a);
            take_bits(8, b);
            take_bits(4, bits);
            divide_and_flush(a | 32'h8000_0000, b | 32'h1, int'(bits));
            random_operands(a, b, s);
            divide(a, b, s, 1'b0);
        end

        repeat (4) @(posedge clk);
        if (done_cnt != expect_done) begin
            stop_with_failure($sformatf("saw %0d completed divisions instead of %0d",
                                        done_cnt, expect_done));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: norm_divider.f
+incdir+bench
src/norm_div_pkg.sv
src/div_operand_prep.sv
src/div_iter_core.sv
src/norm_divider.sv
bench/tb_norm_divider.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_norm_divider
RTL_TOP    := norm_divider
FILELIST   := norm_divider.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero on $$fatal, so make fails with the test
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
